// ==== hdl/dcache_pkg.sv ====
package dcache_pkg;

  // word and address geometry
  localparam int unsigned XLEN   = 32;
  localparam int unsigned ADDR_W = 16;
  localparam int unsigned BE_W   = XLEN / 8;
  localparam int unsigned BSEL_W = $clog2(BE_W);

  typedef logic [XLEN-1:0]   word_t;
  typedef logic [ADDR_W-1:0] adr_t;
  typedef logic [BE_W-1:0]   be_t;

  typedef enum logic [1:0] {
    SIZE_BYTE,
    SIZE_HALF,
    SIZE_WORD
  } size_t;

  // commands from the controller to the bus master
  typedef enum logic [1:0] {
    LINE_NOP,
    LINE_EVICT,
    LINE_FILL
  } line_cmd_t;

  function automatic int unsigned idx_bits(int unsigned sets);
    return $clog2(sets);
  endfunction

  function automatic int unsigned offs_bits(int unsigned words);
    return $clog2(words);
  endfunction

  // whatever is left above index, word offset and byte select
  function automatic int unsigned tag_bits(int unsigned sets, int unsigned words);
    return ADDR_W - idx_bits(sets) - offs_bits(words) - BSEL_W;
  endfunction

endpackage

// ==== hdl/dcache_req_if.sv ====
`timescale 1ns/1ns

interface dcache_req_if #(
  parameter int unsigned SETS       = 8,
  parameter int unsigned LINE_WORDS = 4
);

  localparam int unsigned IDX_W  = dcache_pkg::idx_bits(SETS);
  localparam int unsigned OFFS_W = dcache_pkg::offs_bits(LINE_WORDS);
  localparam int unsigned TAG_W  = dcache_pkg::tag_bits(SETS, LINE_WORDS);

  logic              valid;
  logic              we;
  logic [TAG_W-1:0]  tag;
  logic [IDX_W-1:0]  idx;
  logic [OFFS_W-1:0] offs;
  dcache_pkg::be_t   be;
  dcache_pkg::word_t wdata;
  // ack cycle of the controller
  logic              done;

  modport source (output valid, we, tag, idx, offs, be, wdata, input done);
  modport sink   (input valid, we, tag, idx, offs, be, wdata, output done);

endinterface

// ==== hdl/dcache_line_if.sv ====
`timescale 1ns/1ns

interface dcache_line_if #(
  parameter int unsigned LINE_WORDS = 4
);

  // held until done or err, then back to nop
  dcache_pkg::line_cmd_t cmd;
  dcache_pkg::adr_t      line_adr;

  // victim line going out, fill line coming back
  logic [LINE_WORDS-1:0][dcache_pkg::XLEN-1:0] wline;
  logic [LINE_WORDS-1:0][dcache_pkg::XLEN-1:0] rline;

  logic done;
  logic err;

  modport source (
    output cmd, line_adr, wline,
    input  rline, done, err
  );

  modport sink (
    input  cmd, line_adr, wline,
    output rline, done, err
  );

endinterface

// ==== hdl/dcache_ram.sv ====
`timescale 1ns/1ns

module dcache_ram #(
  parameter int unsigned DEPTH   = 8,
  parameter type         entry_t = logic
) (
  input  logic                     clk_i,
  input  logic                     we_i,
  input  logic [$clog2(DEPTH)-1:0] addr_i,
  input  entry_t                   wdata_i,
  output entry_t                   rdata_o
);

  entry_t mem_q [DEPTH];

  // read returns the old entry when written in the same cycle
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem_q[addr_i] <= wdata_i;
    end
    rdata_o <= mem_q[addr_i];
  end

endmodule

// ==== hdl/dcache_req_stage.sv ====
`timescale 1ns/1ns

module dcache_req_stage #(
  parameter int unsigned SETS       = 8,
  parameter int unsigned LINE_WORDS = 4
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req_i,
  input  logic              we_i,
  input  dcache_pkg::adr_t  adr_i,
  input  dcache_pkg::size_t size_i,
  input  dcache_pkg::word_t d_i,
  output logic              stall_o,
  dcache_req_if.source      req
);

  localparam int unsigned IDX_W  = dcache_pkg::idx_bits(SETS);
  localparam int unsigned OFFS_W = dcache_pkg::offs_bits(LINE_WORDS);
  localparam int unsigned BSEL_W = dcache_pkg::BSEL_W;

  logic                    accept;
  logic [BSEL_W-1:0]       bsel;
  dcache_pkg::be_t         be_d;

  assign bsel    = adr_i[BSEL_W-1:0];
  assign stall_o = req.valid & ~req.done;
  assign accept  = req_i & ~stall_o;

  // lanes touched by the access
  always_comb begin
    case (size_i)
      dcache_pkg::SIZE_BYTE: be_d = dcache_pkg::be_t'(1) << bsel;
      dcache_pkg::SIZE_HALF: be_d = dcache_pkg::be_t'(3) << bsel;
      default:               be_d = '1;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req.valid <= 1'b0;
    end else if (accept) begin
      req.valid <= 1'b1;
    end else if (req.done) begin
      req.valid <= 1'b0;
    end
  end

  // address split and store data moved onto its byte lanes
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req.we    <= we_i;
      req.tag   <= adr_i[dcache_pkg::ADDR_W-1:IDX_W+OFFS_W+BSEL_W];
      req.idx   <= adr_i[OFFS_W+BSEL_W +: IDX_W];
      req.offs  <= adr_i[BSEL_W +: OFFS_W];
      req.be    <= be_d;
      req.wdata <= d_i << {bsel, 3'b000};
    end
  end

endmodule

// ==== hdl/dcache_ctrl.sv ====
`timescale 1ns/1ns

module dcache_ctrl #(
  parameter int unsigned SETS       = 8,
  parameter int unsigned LINE_WORDS = 4
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  dcache_req_if.sink        req,
  dcache_line_if.source     line,
  output logic              ack_o,
  output logic              err_o,
  output dcache_pkg::word_t q_o
);

  localparam int unsigned OFFS_W = dcache_pkg::offs_bits(LINE_WORDS);
  localparam int unsigned TAG_W  = dcache_pkg::tag_bits(SETS, LINE_WORDS);
  localparam int unsigned BSEL_W = dcache_pkg::BSEL_W;

  typedef logic [TAG_W-1:0]                           tag_t;
  typedef logic [LINE_WORDS-1:0][dcache_pkg::XLEN-1:0] line_t;
  typedef enum logic [2:0] {ARMED, LOOKUP, EVICT, FILL, RECOVER} state_t;

  state_t            state_q;
  logic [SETS-1:0]   valid_q;
  logic [SETS-1:0]   dirty_q;
  tag_t              tag_rdata;
  line_t             line_rdata;
  line_t             line_wdata;
  line_t             merged;
  logic              hit;
  logic              tag_we;
  logic              line_we;
  logic [BSEL_W-1:0] lo_byte;
  dcache_pkg::word_t masked;

  ////////////////////////////////////////////////////////////////////////////
  // tag and data storage addressed by the request index
  ////////////////////////////////////////////////////////////////////////////

  dcache_ram #(.DEPTH(SETS), .entry_t(tag_t)) tag_ram_i (
    .clk_i   (clk_i),
    .we_i    (tag_we),
    .addr_i  (req.idx),
    .wdata_i (req.tag),
    .rdata_o (tag_rdata)
  );

  dcache_ram #(.DEPTH(SETS), .entry_t(line_t)) data_ram_i (
    .clk_i   (clk_i),
    .we_i    (line_we),
    .addr_i  (req.idx),
    .wdata_i (line_wdata),
    .rdata_o (line_rdata)
  );

  assign hit        = valid_q[req.idx] && (tag_rdata == req.tag);
  assign tag_we     = (state_q == FILL) && line.done;
  assign line_we    = tag_we || ((state_q == LOOKUP) && hit && req.we);
  assign line_wdata = (state_q == FILL) ? line.rline : merged;
  assign line.wline = line_rdata;
  assign req.done   = ack_o;

  // store merge and load extraction
  always_comb begin
    merged  = line_rdata;
    lo_byte = '0;
    for (int b = 0; b < dcache_pkg::BE_W; b++) begin
      if (req.be[b]) begin
        merged[req.offs][8*b +: 8] = req.wdata[8*b +: 8];
      end
      masked[8*b +: 8] = req.be[b] ? line_rdata[req.offs][8*b +: 8] : 8'h00;
    end
    for (int b = dcache_pkg::BE_W - 1; b >= 0; b--) begin
      if (req.be[b]) begin
        lo_byte = BSEL_W'(b);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // controller FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= ARMED;
      valid_q  <= '0;
      dirty_q  <= '0;
      ack_o    <= 1'b0;
      err_o    <= 1'b0;
      line.cmd <= dcache_pkg::LINE_NOP;
    end else begin
      ack_o <= 1'b0;
      err_o <= 1'b0;
      case (state_q)
        ARMED: begin
          // ignore the request still showing in its own ack cycle
          if (req.valid && !req.done) begin
            state_q <= LOOKUP;
          end
        end
        LOOKUP: begin
          if (hit) begin
            ack_o   <= 1'b1;
            state_q <= ARMED;
            if (req.we) begin
              dirty_q[req.idx] <= 1'b1;
            end
          end else if (valid_q[req.idx] && dirty_q[req.idx]) begin
            line.cmd <= dcache_pkg::LINE_EVICT;
            state_q  <= EVICT;
          end else begin
            state_q <= FILL;
          end
        end
        EVICT: begin
          if (line.done || line.err) begin
            line.cmd         <= dcache_pkg::LINE_NOP;
            dirty_q[req.idx] <= 1'b0;
            state_q          <= FILL;
            if (line.err) begin
              valid_q[req.idx] <= 1'b0;
              ack_o            <= 1'b1;
              err_o            <= 1'b1;
              state_q          <= ARMED;
            end
          end
        end
        FILL: begin
          if (line.cmd == dcache_pkg::LINE_NOP) begin
            line.cmd <= dcache_pkg::LINE_FILL;
          end else if (line.done) begin
            line.cmd         <= dcache_pkg::LINE_NOP;
            valid_q[req.idx] <= 1'b1;
            dirty_q[req.idx] <= 1'b0;
            state_q          <= RECOVER;
          end else if (line.err) begin
            line.cmd         <= dcache_pkg::LINE_NOP;
            valid_q[req.idx] <= 1'b0;
            ack_o            <= 1'b1;
            err_o            <= 1'b1;
            state_q          <= ARMED;
          end
        end
        // array read again, then lookup hits
        RECOVER: state_q <= LOOKUP;
        default: state_q <= ARMED;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == LOOKUP) begin
      line.line_adr <= {tag_rdata, req.idx, {(OFFS_W+BSEL_W){1'b0}}};
    end
    if ((state_q == FILL) && (line.cmd == dcache_pkg::LINE_NOP)) begin
      line.line_adr <= {req.tag, req.idx, {(OFFS_W+BSEL_W){1'b0}}};
    end
    if ((state_q == LOOKUP) && hit) begin
      q_o <= masked >> {lo_byte, 3'b000};
    end
  end

endmodule

// ==== hdl/dcache_wb_master.sv ====
`timescale 1ns/1ns

module dcache_wb_master #(
  parameter int unsigned LINE_WORDS = 4
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  dcache_line_if.sink       line,
  output logic              wb_cyc_o,
  output logic              wb_stb_o,
  output logic              wb_we_o,
  output dcache_pkg::adr_t  wb_adr_o,
  output dcache_pkg::be_t   wb_sel_o,
  output dcache_pkg::word_t wb_dat_o,
  input  dcache_pkg::word_t wb_dat_i,
  input  logic              wb_ack_i,
  input  logic              wb_err_i
);

  localparam int unsigned OFFS_W = dcache_pkg::offs_bits(LINE_WORDS);
  localparam int unsigned BSEL_W = dcache_pkg::BSEL_W;

  typedef enum logic [1:0] {IDLE, BUS, GAP, DONE} state_t;

  state_t            state_q;
  logic [OFFS_W-1:0] cnt_q;
  logic              last;

  assign last     = (cnt_q == OFFS_W'(LINE_WORDS - 1));
  assign wb_adr_o = {line.line_adr[dcache_pkg::ADDR_W-1:OFFS_W+BSEL_W], cnt_q,
                     {BSEL_W{1'b0}}};
  assign wb_dat_o = line.wline[cnt_q];
  assign wb_sel_o = '1;

  ////////////////////////////////////////////////////////////////////////////
  // one classic cycle per word with stb low for a cycle in between
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= IDLE;
      cnt_q     <= '0;
      wb_cyc_o  <= 1'b0;
      wb_stb_o  <= 1'b0;
      wb_we_o   <= 1'b0;
      line.done <= 1'b0;
      line.err  <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (line.cmd != dcache_pkg::LINE_NOP) begin
            wb_cyc_o <= 1'b1;
            wb_stb_o <= 1'b1;
            wb_we_o  <= (line.cmd == dcache_pkg::LINE_EVICT);
            cnt_q    <= '0;
            state_q  <= BUS;
          end
        end
        BUS: begin
          if (wb_err_i) begin
            // first error ends the whole line
            wb_cyc_o <= 1'b0;
            wb_stb_o <= 1'b0;
            line.err <= 1'b1;
            state_q  <= DONE;
          end else if (wb_ack_i) begin
            wb_stb_o <= 1'b0;
            if (last) begin
              wb_cyc_o  <= 1'b0;
              line.done <= 1'b1;
              state_q   <= DONE;
            end else begin
              cnt_q   <= cnt_q + 1'b1;
              state_q <= GAP;
            end
          end
        end
        GAP: begin
          wb_stb_o <= 1'b1;
          state_q  <= BUS;
        end
        default: begin
          // controller drops cmd on this edge
          line.done <= 1'b0;
          line.err  <= 1'b0;
          wb_we_o   <= 1'b0;
          state_q   <= IDLE;
        end
      endcase
    end
  end

  // fill words collected in place
  always_ff @(posedge clk_i) begin
    if ((state_q == BUS) && wb_ack_i && !wb_we_o) begin
      line.rline[cnt_q] <= wb_dat_i;
    end
  end

endmodule

// ==== hdl/dcache_top.sv ====
`timescale 1ns/1ns

module dcache_top #(
  parameter int unsigned SETS       = 8,
  parameter int unsigned LINE_WORDS = 4
) (
  input  logic              clk_i,
  input  logic              rst_ni,

  // core port
  input  logic              req_i,
  input  logic              we_i,
  input  dcache_pkg::adr_t  adr_i,
  input  dcache_pkg::size_t size_i,
  input  dcache_pkg::word_t d_i,
  output logic              stall_o,
  output logic              ack_o,
  output logic              err_o,
  output dcache_pkg::word_t q_o,

  // wishbone classic master
  output logic              wb_cyc_o,
  output logic              wb_stb_o,
  output logic              wb_we_o,
  output dcache_pkg::adr_t  wb_adr_o,
  output dcache_pkg::be_t   wb_sel_o,
  output dcache_pkg::word_t wb_dat_o,
  input  dcache_pkg::word_t wb_dat_i,
  input  logic              wb_ack_i,
  input  logic              wb_err_i
);

  dcache_req_if #(.SETS(SETS), .LINE_WORDS(LINE_WORDS)) req_if_i ();
  dcache_line_if #(.LINE_WORDS(LINE_WORDS)) line_if_i ();

  dcache_req_stage #(.SETS(SETS), .LINE_WORDS(LINE_WORDS)) req_stage_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (req_i),
    .we_i    (we_i),
    .adr_i   (adr_i),
    .size_i  (size_i),
    .d_i     (d_i),
    .stall_o (stall_o),
    .req     (req_if_i.source)
  );

  dcache_ctrl #(.SETS(SETS), .LINE_WORDS(LINE_WORDS)) ctrl_i (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req    (req_if_i.sink),
    .line   (line_if_i.source),
    .ack_o  (ack_o),
    .err_o  (err_o),
    .q_o    (q_o)
  );

  dcache_wb_master #(.LINE_WORDS(LINE_WORDS)) wb_master_i (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .line     (line_if_i.sink),
    .wb_cyc_o (wb_cyc_o),
    .wb_stb_o (wb_stb_o),
    .wb_we_o  (wb_we_o),
    .wb_adr_o (wb_adr_o),
    .wb_sel_o (wb_sel_o),
    .wb_dat_o (wb_dat_o),
    .wb_dat_i (wb_dat_i),
    .wb_ack_i (wb_ack_i),
    .wb_err_i (wb_err_i)
  );

endmodule

// ==== tests/tb_clkgen.sv ====
`timescale 1ns/1ns

module tb_clkgen #(
  parameter int unsigned PERIOD     = 20,
  parameter int unsigned RST_CYCLES = 4
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // released on a falling edge away from the sampling edge
  initial begin
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

// ==== tests/dcache_sva.sv ====
`timescale 1ns/1ns

module dcache_sva (
  input logic              clk_i,
  input logic              rst_ni,
  input logic              core_ack_i,
  input logic              cyc_i,
  input logic              stb_i,
  input logic              we_i,
  input dcache_pkg::adr_t  adr_i,
  input dcache_pkg::word_t dat_i,
  input logic              bus_ack_i,
  input logic              bus_err_i
);

  // stb only inside a bus cycle
  assert property (@(posedge clk_i) disable iff (!rst_ni) stb_i |-> cyc_i)
    else $error("wb_stb_o high without wb_cyc_o");

  // word held until the slave answers
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    stb_i && !bus_ack_i && !bus_err_i |=> $stable(adr_i) && $stable(dat_i) && $stable(we_i))
    else $error("wishbone address or data changed while waiting for ack");

  // ack is a single cycle pulse
  assert property (@(posedge clk_i) disable iff (!rst_ni) core_ack_i |=> !core_ack_i)
    else $error("ack_o high for two cycles in a row");

endmodule

bind dcache_top dcache_sva sva_i (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .core_ack_i (ack_o),
  .cyc_i      (wb_cyc_o),
  .stb_i      (wb_stb_o),
  .we_i       (wb_we_o),
  .adr_i      (wb_adr_o),
  .dat_i      (wb_dat_o),
  .bus_ack_i  (wb_ack_i),
  .bus_err_i  (wb_err_i)
);

// ==== tests/tb_dcache.sv ====
`timescale 1ns/1ns

module tb_dcache;

  localparam int unsigned SETS        = 8;
  localparam int unsigned LINE_WORDS  = 4;
  localparam int unsigned COLS        = 6;
  localparam int unsigned MAX_VEC     = 64;
  localparam int unsigned MEM_WORDS   = 1024;
  localparam int unsigned CYC_PER_VEC = 200;
  localparam dcache_pkg::adr_t  ERR_BASE  = 16'hF000;
  localparam dcache_pkg::word_t OP_STORE  = 32'd1;
  localparam dcache_pkg::word_t OP_HIT    = 32'd2;
  localparam dcache_pkg::word_t OP_MISS   = 32'd3;
  localparam dcache_pkg::word_t OP_EVICT  = 32'd4;
  localparam dcache_pkg::word_t OP_END    = 32'hFF;

  logic              clk;
  logic              rst_n;
  logic              req;
  logic              we;
  dcache_pkg::adr_t  adr;
  dcache_pkg::size_t size;
  dcache_pkg::word_t wdata;
  logic              stall;
  logic              ack;
  logic              err;
  dcache_pkg::word_t q;
  logic              wb_cyc;
  logic              wb_stb;
  logic              wb_we;
  dcache_pkg::adr_t  wb_adr;
  dcache_pkg::be_t   wb_sel;
  dcache_pkg::word_t wb_wdat;
  dcache_pkg::word_t wb_rdat  = '0;
  logic              wb_ack   = 1'b0;
  logic              wb_err   = 1'b0;
  logic              stb_seen = 1'b0;

  dcache_pkg::word_t mem_q [MEM_WORDS];
  dcache_pkg::word_t vec_mem [MAX_VEC*COLS];
  // completed bus words with the write flag in bit 16
  logic [16:0]       xfer_q [$];
  int unsigned       n_vec;
  int unsigned       err_cnt = 0;
  int unsigned       pass_cnt = 0;
  int unsigned       fail_cnt = 0;
  int unsigned       cycles = 0;
  int unsigned       cycle_limit = 1000000;

  tb_clkgen #(.PERIOD(20), .RST_CYCLES(4)) clkgen_i (.clk_o(clk), .rst_no(rst_n));

  dcache_top #(.SETS(SETS), .LINE_WORDS(LINE_WORDS)) dut_i (
    .clk_i    (clk),
    .rst_ni   (rst_n),
    .req_i    (req),
    .we_i     (we),
    .adr_i    (adr),
    .size_i   (size),
    .d_i      (wdata),
    .stall_o  (stall),
    .ack_o    (ack),
    .err_o    (err),
    .q_o      (q),
    .wb_cyc_o (wb_cyc),
    .wb_stb_o (wb_stb),
    .wb_we_o  (wb_we),
    .wb_adr_o (wb_adr),
    .wb_sel_o (wb_sel),
    .wb_dat_o (wb_wdat),
    .wb_dat_i (wb_rdat),
    .wb_ack_i (wb_ack),
    .wb_err_i (wb_err)
  );

  ////////////////////////////////////////////////////////////////////////////
  // wishbone slave memory
  ////////////////////////////////////////////////////////////////////////////

  function automatic dcache_pkg::word_t fill_word(int unsigned w);
    return (w * 32'h0101_0101) ^ 32'hA5A5_0000;
  endfunction

  // answers on the second falling edge that sees stb
  always @(negedge clk) begin
    wb_ack <= 1'b0;
    wb_err <= 1'b0;
    if (wb_cyc && wb_stb && !wb_ack && !wb_err) begin
      if (!stb_seen) begin
        stb_seen <= 1'b1;
      end else begin
        stb_seen <= 1'b0;
        if (wb_adr >= ERR_BASE) begin
          wb_err <= 1'b1;
        end else begin
          wb_ack  <= 1'b1;
          wb_rdat <= mem_q[wb_adr[11:2]];
        end
      end
    end
  end

  // words complete where the master samples ack
  always @(posedge clk) begin
    if (!rst_n) begin
      for (int w = 0; w < MEM_WORDS; w++) begin
        mem_q[w] <= fill_word(w);
      end
    end else if (wb_cyc && wb_stb && wb_ack) begin
      xfer_q.push_back({wb_we, wb_adr});
      // every word moves with all byte lanes selected
      check_sel("wb_sel_o", wb_sel, '1);
      if (wb_we) begin
        mem_q[wb_adr[11:2]] <= wb_wdat;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Errors found");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_word(input string name, input dcache_pkg::word_t got,
                            input dcache_pkg::word_t exp);
    if (got !== exp) begin
      $display("Error: %s is %h, expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error: %s is %h, expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_adr(input string name, input dcache_pkg::adr_t got,
                           input dcache_pkg::adr_t exp);
    if (got !== exp) begin
      $display("Error: %s is %h, expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_sel(input string name, input dcache_pkg::be_t got,
                           input dcache_pkg::be_t exp);
    if (got !== exp) begin
      $display("Error: %s is %h, expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic report_problem(input int unsigned n, input string what);
    $display("test %0d: %s", n + 1, what);
    err_cnt++;
  endtask

  task automatic close_test(input string label, input int unsigned errs_before);
    if (err_cnt == errs_before) begin
      pass_cnt++;
      $display("%s: pass", label);
    end else begin
      fail_cnt++;
      $display("%s: FAIL", label);
    end
  endtask

  // one vector from the negedge it starts on to the negedge that shows ack
  task automatic run_vector(input int unsigned n);
    dcache_pkg::word_t op;
    dcache_pkg::word_t exp_q;
    dcache_pkg::adr_t  vadr;
    dcache_pkg::adr_t  wb_base;
    logic              exp_err;
    int unsigned       errs_before;
    int unsigned       lat;
    int unsigned       nrd;
    int unsigned       nwr;
    int                first;
    op          = vec_mem[n*COLS];
    vadr        = vec_mem[n*COLS+1][15:0];
    wb_base     = vec_mem[n*COLS+3][15:0];
    exp_q       = vec_mem[n*COLS+4];
    exp_err     = vec_mem[n*COLS+5][0];
    errs_before = err_cnt;
    first       = xfer_q.size();
    req   = 1'b1;
    we    = (op == OP_STORE);
    adr   = vadr;
    size  = dcache_pkg::size_t'(vec_mem[n*COLS+2][1:0]);
    wdata = vec_mem[n*COLS+3];
    while (stall) begin
      @(negedge clk);
    end
    @(negedge clk);
    req = 1'b0;
    lat = 0;
    while (!ack) begin
      @(negedge clk);
      lat++;
    end
    check_flag("err_o", err, exp_err);
    if (op != OP_STORE && !exp_err) begin
      check_word("q_o", q, exp_q);
    end
    nrd = 0;
    nwr = 0;
    for (int i = first; i < xfer_q.size(); i++) begin
      if (xfer_q[i][16]) begin
        nwr++;
      end else begin
        nrd++;
      end
    end
    if (op == OP_HIT && lat != 2) begin
      report_problem(n, $sformatf("hit acknowledged after %0d cycles, not 2", lat));
    end
    if (op == OP_HIT && (nrd + nwr) != 0) begin
      report_problem(n, "a hit caused bus traffic");
    end
    if ((op == OP_MISS || op == OP_EVICT) && nrd < LINE_WORDS) begin
      report_problem(n, $sformatf("miss made only %0d bus reads", nrd));
    end
    if (op == OP_MISS && nwr != 0) begin
      report_problem(n, "a clean miss wrote to the bus");
    end
    if (op == OP_EVICT) begin
      if (nwr != LINE_WORDS) begin
        report_problem(n, $sformatf("write-back made %0d bus writes", nwr));
      end
      // victim words go out first at ascending addresses
      for (int i = 0; i < LINE_WORDS; i++) begin
        if (first + i < xfer_q.size()) begin
          if (!xfer_q[first+i][16]) begin
            report_problem(n, "line fill started before the write-back ended");
          end
          check_adr("wb_adr_o", xfer_q[first+i][15:0],
                    wb_base + dcache_pkg::adr_t'(4 * i));
        end
      end
    end
    close_test($sformatf("test %0d op %0d adr %h", n + 1, op, vadr), errs_before);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int unsigned errs_before;
    req   = 1'b0;
    we    = 1'b0;
    adr   = '0;
    size  = dcache_pkg::SIZE_WORD;
    wdata = '0;
    for (int i = 0; i < MAX_VEC*COLS; i++) begin
      vec_mem[i] = OP_END;
    end
    $readmemh("tests/dcache_vectors.txt", vec_mem);
    n_vec = 0;
    while (n_vec < MAX_VEC && vec_mem[n_vec*COLS] != OP_END) begin
      n_vec++;
    end
    cycle_limit = CYC_PER_VEC * (n_vec + 1);
    wait (rst_n);
    @(negedge clk);
    errs_before = err_cnt;
    check_flag("stall_o", stall, 1'b0);
    check_flag("ack_o", ack, 1'b0);
    check_flag("err_o", err, 1'b0);
    check_flag("wb_cyc_o", wb_cyc, 1'b0);
    close_test("test 0 reset", errs_before);
    for (int unsigned n = 0; n < n_vec; n++) begin
      run_vector(n);
    end
    $display("%0d tests, %0d passed, %0d failed", pass_cnt + fail_cnt, pass_cnt, fail_cnt);
    if (err_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== dcache_top.f ====
hdl/dcache_pkg.sv
hdl/dcache_req_if.sv
hdl/dcache_line_if.sv
hdl/dcache_ram.sv
hdl/dcache_req_stage.sv
hdl/dcache_ctrl.sv
hdl/dcache_wb_master.sv
hdl/dcache_top.sv
tests/tb_clkgen.sv
tests/dcache_sva.sv
tests/tb_dcache.sv

// ==== Makefile ====
# Verilator build for the data cache testbench

VERILATOR ?= verilator
TOP       ?= tb_dcache
FILELIST  ?= dcache_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell cat $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM) | tee $(LOG)
	@if grep -q "Errors found" $(LOG) || ! grep -q "No errors" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	else \
	  echo "simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tests/dcache_vectors.txt ====
// op adr size data exp_q exp_err   (size 0 byte, 1 half, 2 word)
// op 0 load, 1 store, 2 load hit, 3 load miss, 4 load miss writing back line at data
3 0040 2 00000000 B5B51010 0
2 0040 2 00000000 B5B51010 0
2 004C 2 00000000 B6B61313 0
1 0041 0 000000CC 00000000 0
1 0046 1 00001234 00000000 0
2 0040 2 00000000 B5B5CC10 0
2 0044 2 00000000 12341111 0
2 0041 0 00000000 000000CC 0
2 0046 1 00000000 00001234 0
4 00C0 2 00000040 95953030 0
3 0040 2 00000000 B5B5CC10 0
2 0044 2 00000000 12341111 0
0 F000 2 00000000 00000000 1
3 0000 2 00000000 A5A50000 0
1 0104 2 DEADBEEF 00000000 0
2 0104 2 00000000 DEADBEEF 0
4 0000 2 00000100 A5A50000 0
3 0104 2 00000000 DEADBEEF 0
1 F010 2 00000000 00000000 1
2 0040 2 00000000 B5B5CC10 0
// end marker
FF 0000 0 00000000 00000000 0
